//--- sync_receiver.f
common/receiver_pkg.sv
hdl/sample_decimator.sv
pss_detector/pss_detector.sv
hdl/sample_delay.sv
hdl/frame_sync.sv
hdl/sync_receiver.sv
sim/clock_gen.sv
sim/sync_receiver_checker.sv
sim/sync_receiver_tb.sv

//--- sim/sync_receiver_tb.sv
`timescale 1ns/1ps

module sync_receiver_tb;

    localparam int PSS_THRESH = 14;
    localparam int SYMBOL_LEN = 8;
    localparam int SAMPLE_W = receiver_pkg::SAMPLE_W;
    localparam int IQ_W = receiver_pkg::IQ_W;
    localparam int NID2_W = receiver_pkg::NID2_W;
    localparam int PSS_LEN = receiver_pkg::PSS_LEN;
    localparam int BURST = 3 * SYMBOL_LEN;
    localparam int TAIL = 4;
    localparam int NONE = 3;

    logic                clk_i;
    logic                reset_ni;
    logic [SAMPLE_W-1:0] in_data_i;
    logic                in_valid_i;
    logic [NID2_W-1:0]   n_id_2_o;
    logic                n_id_2_valid_o;
    logic [SAMPLE_W-1:0] out_data_o;
    logic                out_valid_o;
    logic                symbol_start_o;
    logic                pbch_start_o;
    logic                sss_start_o;

    // test table columns
    string row_name [$];
    int    row_idx [$];
    int    row_flips [$];
    int    row_noise [$];
    bit    row_second [$];

    // an output event is the sample followed by symbol, pbch and sss markers
    logic [NID2_W-1:0]   exp_id [$];
    logic [NID2_W-1:0]   got_id [$];
    logic [SAMPLE_W+2:0] exp_out [$];
    logic [SAMPLE_W+2:0] got_out [$];
    logic [PSS_LEN-1:0]  ref_win;
    int                  ref_left;
    int                  ref_pos;
    int                  errors;
    int                  passed;
    int                  failed;

    clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (2)
    ) clock_gen_i (
        .clk_o    (clk_i),
        .reset_no (reset_ni)
    );

    sync_receiver #(
        .PSS_THRESH (PSS_THRESH),
        .SYMBOL_LEN (SYMBOL_LEN)
    ) dut (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .in_data_i      (in_data_i),
        .in_valid_i     (in_valid_i),
        .n_id_2_o       (n_id_2_o),
        .n_id_2_valid_o (n_id_2_valid_o),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .sss_start_o    (sss_start_o)
    );

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (reset_ni && n_id_2_valid_o) begin
            got_id.push_back(n_id_2_o);
        end
        if (reset_ni && out_valid_o) begin
            got_out.push_back({out_data_o, symbol_start_o, pbch_start_o, sss_start_o});
        end
    end

    task automatic add_row(input string name, input int idx, input int flips,
                           input int noise, input bit second);
        row_name.push_back(name);
        row_idx.push_back(idx);
        row_flips.push_back(flips);
        row_noise.push_back(noise);
        row_second.push_back(second);
    endtask

    // receiver model, one call per decimated sample
    task automatic model_sample(input logic [SAMPLE_W-1:0] d);
        int   n;
        int   sel;
        logic first;
        ref_win = {ref_win[PSS_LEN-2:0], $signed(d[IQ_W-1:0]) >= 0};
        if (ref_left == 0) begin
            sel = -1;
            for (int k = 0; k < 3; k++) begin
                n = 0;
                for (int b = 0; b < PSS_LEN; b++) begin
                    n += (ref_win[b] == receiver_pkg::PSS_SEQ[k][b]);
                end
                if (sel < 0 && n >= PSS_THRESH) begin
                    sel = k;
                end
            end
            if (sel >= 0) begin
                exp_id.push_back(NID2_W'(sel));
                ref_left = BURST;
                ref_pos = 0;
            end
        end else begin
            first = (ref_pos % SYMBOL_LEN) == 0;
            exp_out.push_back({d, first, first && (ref_pos / SYMBOL_LEN != 1),
                               first && (ref_pos / SYMBOL_LEN == 1)});
            ref_pos++;
            ref_left--;
        end
    endtask

    function automatic logic [SAMPLE_W-1:0] make_input(input bit positive);
        logic [IQ_W-1:0] mag;
        mag = IQ_W'($urandom % 16384);
        // ~mag is -(mag + 1), which keeps the sign strict
        return {IQ_W'($urandom), positive ? mag : ~mag};
    endfunction

    function automatic logic [SAMPLE_W-1:0] pair_average(input logic [SAMPLE_W-1:0] a,
                                                        input logic [SAMPLE_W-1:0] b);
        int re;
        int im;
        re = (int'($signed(a[IQ_W-1:0])) + int'($signed(b[IQ_W-1:0]))) >>> 1;
        im = (int'($signed(a[SAMPLE_W-1:IQ_W])) + int'($signed(b[SAMPLE_W-1:IQ_W]))) >>> 1;
        return {IQ_W'(im), IQ_W'(re)};
    endfunction

    task automatic drive_sample(input logic [SAMPLE_W-1:0] d);
        @(posedge clk_i);
        if ($urandom % 4 == 0) begin
            in_valid_i <= 1'b0;
            @(posedge clk_i);
        end
        in_data_i  <= d;
        in_valid_i <= 1'b1;
    endtask

    // one decimated sample whose real part has the given sign
    task automatic send_bit(input bit positive);
        logic [SAMPLE_W-1:0] a;
        logic [SAMPLE_W-1:0] b;
        a = make_input(positive);
        b = make_input(positive);
        model_sample(pair_average(a, b));
        drive_sample(a);
        drive_sample(b);
    endtask

    task automatic run_row(input int r);
        logic [PSS_LEN-1:0] pat;
        logic [PSS_LEN-1:0] inner;
        for (int i = 0; i < row_noise[r]; i++) begin
            send_bit($urandom % 2 == 1);
        end
        if (row_idx[r] != NONE) begin
            pat = receiver_pkg::PSS_SEQ[row_idx[r]];
            for (int j = 0; j < row_flips[r]; j++) begin
                pat[(j * 5) % PSS_LEN] = ~pat[(j * 5) % PSS_LEN];
            end
            for (int i = PSS_LEN - 1; i >= 0; i--) begin
                send_bit(pat[i]);
            end
        end
        inner = receiver_pkg::PSS_SEQ[(row_idx[r] + 1) % 3];
        for (int i = 0; i < BURST + TAIL; i++) begin
            if (row_second[r] && i >= 4 && i < 4 + PSS_LEN) begin
                send_bit(inner[PSS_LEN + 3 - i]);
            end else begin
                send_bit($urandom % 2 == 1);
            end
        end
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int bad, input int n_det,
                               input int n_out);
        if (errors == bad) begin
            passed++;
            $display("%s: pass, %0d detections, %0d burst samples", name, n_det, n_out);
        end else begin
            failed++;
            $display("%s: FAIL, %0d errors", name, errors - bad);
        end
    endtask

    task automatic check_row(input int r);
        int                  wait_cycles;
        int                  bad;
        int                  n_det;
        int                  n_out;
        logic [NID2_W-1:0]   e_id;
        logic [SAMPLE_W+2:0] e_out;
        bad = errors;
        n_det = exp_id.size();
        n_out = exp_out.size();
        wait_cycles = 0;
        while ((got_id.size() < n_det || got_out.size() < n_out) && wait_cycles < 100) begin
            @(posedge clk_i);
            wait_cycles++;
        end
        // anything unexpected shows up within the output latency
        repeat (8) @(posedge clk_i);
        assert (wait_cycles < 100) else begin
            $display("%s: expected outputs did not arrive within 100 cycles", row_name[r]);
            errors++;
        end
        assert (got_id.size() == n_det) else begin
            $display("ERR %s detections expected %0d actual %0d", row_name[r], n_det,
                     got_id.size());
            errors++;
        end
        assert (got_out.size() == n_out) else begin
            $display("ERR %s burst samples expected %0d actual %0d", row_name[r], n_out,
                     got_out.size());
            errors++;
        end
        while (exp_id.size() > 0 && got_id.size() > 0) begin
            e_id = exp_id.pop_front();
            assert (got_id[0] == e_id) else begin
                $display("ERR %s n_id_2 expected %0d actual %0d", row_name[r], e_id, got_id[0]);
                errors++;
            end
            got_id.delete(0);
        end
        while (exp_out.size() > 0 && got_out.size() > 0) begin
            e_out = exp_out.pop_front();
            assert (got_out[0] == e_out) else begin
                $display("ERR %s sample+markers expected %h actual %h", row_name[r], e_out,
                         got_out[0]);
                errors++;
            end
            got_out.delete(0);
        end
        exp_id.delete();
        got_id.delete();
        exp_out.delete();
        got_out.delete();
        finish_test(row_name[r], bad, n_det, n_out);
    endtask

    task automatic check_idle();
        logic [4:0] flags;
        flags = {out_valid_o, n_id_2_valid_o, symbol_start_o, pbch_start_o, sss_start_o};
        assert (flags == 5'b0) else begin
            $display("ERR reset output flags expected %b actual %b", 5'b0, flags);
            errors++;
        end
    endtask

    initial begin
        int bad;
        in_data_i  = '0;
        in_valid_i = 1'b0;
        errors = 0;
        passed = 0;
        failed = 0;
        ref_win = '0;
        ref_left = 0;
        ref_pos = 0;
        void'($urandom(9343));
        add_row("noise_only", NONE, 0, 40, 1'b0);
        add_row("detect_0", 0, 0, 12, 1'b0);
        add_row("detect_1", 1, 0, 12, 1'b0);
        add_row("detect_2", 2, 0, 12, 1'b0);
        add_row("thresh_pass", 1, PSS_LEN - PSS_THRESH, 12, 1'b0);
        add_row("thresh_miss", 2, PSS_LEN - PSS_THRESH + 1, 12, 1'b0);
        add_row("locked_ignore", 0, 0, 12, 1'b1);
        add_row("redetect", 2, 1, 8, 1'b0);
        bad = errors;
        // first falling edge after the first reset edge
        @(posedge clk_i);
        @(negedge clk_i);
        check_idle();
        while (!reset_ni) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        check_idle();
        finish_test("reset", bad, 0, 0);
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
            check_row(r);
        end
        $display("summary: %0d passed, %0d failed, %0d checker failures", passed, failed,
                 dut.checker_i.fail_cnt);
        if (failed == 0 && errors == 0 && dut.checker_i.fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // each input takes at most 2 cycles, allow twice that plus settling
    initial begin
        int total;
        int limit_ns;
        #1;
        total = 0;
        for (int r = 0; r < row_noise.size(); r++) begin
            total += 2 * (row_noise[r] + BURST + TAIL + (row_idx[r] != NONE ? PSS_LEN : 0));
        end
        limit_ns = 2 * total * 2 * 8 + 4000;
        #(limit_ns);
        $display("watchdog: simulation timed out after %0d ns", limit_ns);
        $display("tests failed");
        $finish;
    end

endmodule

//--- sim/sync_receiver_checker.sv
`timescale 1ns/1ps

module sync_receiver_checker (
    input logic clk_i,
    input logic reset_ni,
    input logic n_id_2_valid_i,
    input logic out_valid_i,
    input logic symbol_start_i,
    input logic pbch_start_i,
    input logic sss_start_i
);

    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // a symbol start carries one ssb marker only
    marker_excl: assert property (@(posedge clk_i) disable iff (!reset_ni)
        !(pbch_start_i && sss_start_i))
        else begin
            $error("pbch and sss markers high in the same cycle");
            fail_cnt++;
        end

    marker_on_sample: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (symbol_start_i || pbch_start_i || sss_start_i) |-> (symbol_start_i && out_valid_i))
        else begin
            $error("marker without a symbol start on a valid output sample");
            fail_cnt++;
        end

    // one detection per lock
    nid_single: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_2_valid_i |=> !n_id_2_valid_i)
        else begin
            $error("n_id_2_valid_o high in two consecutive cycles");
            fail_cnt++;
        end

endmodule

bind sync_receiver sync_receiver_checker checker_i (
    .clk_i          (clk_i),
    .reset_ni       (reset_ni),
    .n_id_2_valid_i (n_id_2_valid_o),
    .out_valid_i    (out_valid_o),
    .symbol_start_i (symbol_start_o),
    .pbch_start_i   (pbch_start_o),
    .sss_start_i    (sss_start_o)
);

//--- sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o    = 1'b0;
        reset_no = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

    // reset is synchronous, so release it on a rising edge
    initial begin
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_no <= 1'b1;
    end

endmodule

//--- hdl/sync_receiver.sv
`timescale 1ns/1ps

module sync_receiver #(
    parameter int PSS_THRESH = 14,
    parameter int SYMBOL_LEN = 8
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic [receiver_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                              in_valid_i,
    output logic [receiver_pkg::NID2_W-1:0]   n_id_2_o,
    output logic                              n_id_2_valid_o,
    output logic [receiver_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                              out_valid_o,
    output logic                              symbol_start_o,
    output logic                              pbch_start_o,
    output logic                              sss_start_o
);

    logic [receiver_pkg::SAMPLE_W-1:0] dec_data;
    logic                              dec_valid;
    logic [receiver_pkg::SAMPLE_W-1:0] dly_data;
    logic                              dly_valid;
    logic                              peak_valid;
    logic [receiver_pkg::NID2_W-1:0]   peak_id;
    logic                              search_en;

    sample_decimator sample_decimator_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (in_data_i),
        .in_valid_i  (in_valid_i),
        .dec_data_o  (dec_data),
        .dec_valid_o (dec_valid)
    );

    pss_detector #(
        .PSS_THRESH (PSS_THRESH)
    ) pss_detector_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .dec_data_i   (dec_data),
        .dec_valid_i  (dec_valid),
        .search_en_i  (search_en),
        .peak_valid_o (peak_valid),
        .peak_id_o    (peak_id)
    );

    // two cycles matches the detector latency, so the last sequence
    // sample arrives together with the peak
    sample_delay #(
        .DEPTH (2)
    ) sample_delay_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (dec_data),
        .in_valid_i  (dec_valid),
        .out_data_o  (dly_data),
        .out_valid_o (dly_valid)
    );

    frame_sync #(
        .SYMBOL_LEN (SYMBOL_LEN)
    ) frame_sync_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .peak_valid_i   (peak_valid),
        .peak_id_i      (peak_id),
        .dly_data_i     (dly_data),
        .dly_valid_i    (dly_valid),
        .search_en_o    (search_en),
        .n_id_2_o       (n_id_2_o),
        .n_id_2_valid_o (n_id_2_valid_o),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .symbol_start_o (symbol_start_o),
        .pbch_start_o   (pbch_start_o),
        .sss_start_o    (sss_start_o)
    );

endmodule

//--- hdl/frame_sync.sv
`timescale 1ns/1ps

module frame_sync #(
    parameter int SYMBOL_LEN = 8
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic                              peak_valid_i,
    input  logic [receiver_pkg::NID2_W-1:0]   peak_id_i,
    input  logic [receiver_pkg::SAMPLE_W-1:0] dly_data_i,
    input  logic                              dly_valid_i,
    output logic                              search_en_o,
    output logic [receiver_pkg::NID2_W-1:0]   n_id_2_o,
    output logic                              n_id_2_valid_o,
    output logic [receiver_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                              out_valid_o,
    output logic                              symbol_start_o,
    output logic                              pbch_start_o,
    output logic                              sss_start_o
);

    localparam int CNT_W = (SYMBOL_LEN > 1) ? $clog2(SYMBOL_LEN) : 1;

    typedef enum logic {
        ST_SEARCH,
        ST_LOCKED
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] samp_cnt_q;
    logic [1:0]       sym_cnt_q;
    logic             sym_first;
    logic             sym_last;
    logic             burst_last;
    logic             lock_now;

    assign search_en_o = (state_q == ST_SEARCH);
    assign lock_now    = search_en_o && peak_valid_i;
    assign sym_first   = (samp_cnt_q == '0);
    assign sym_last    = (samp_cnt_q == CNT_W'(SYMBOL_LEN - 1));
    // an ssb here is pbch, sss, pbch
    assign burst_last  = sym_last && (sym_cnt_q == 2'd2);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q        <= ST_SEARCH;
            samp_cnt_q     <= '0;
            sym_cnt_q      <= '0;
            n_id_2_valid_o <= 1'b0;
            out_valid_o    <= 1'b0;
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            sss_start_o    <= 1'b0;
        end else begin
            n_id_2_valid_o <= lock_now;
            out_valid_o    <= 1'b0;
            symbol_start_o <= 1'b0;
            pbch_start_o   <= 1'b0;
            sss_start_o    <= 1'b0;
            case (state_q)
                ST_SEARCH: begin
                    if (peak_valid_i) begin
                        state_q    <= ST_LOCKED;
                        samp_cnt_q <= '0;
                        sym_cnt_q  <= '0;
                    end
                end
                ST_LOCKED: begin
                    if (dly_valid_i) begin
                        out_valid_o    <= 1'b1;
                        symbol_start_o <= sym_first;
                        pbch_start_o   <= sym_first && (sym_cnt_q != 2'd1);
                        sss_start_o    <= sym_first && (sym_cnt_q == 2'd1);
                        if (sym_last) begin
                            samp_cnt_q <= '0;
                            sym_cnt_q  <= burst_last ? 2'd0 : sym_cnt_q + 2'd1;
                        end else begin
                            samp_cnt_q <= samp_cnt_q + CNT_W'(1);
                        end
                        // back to searching after the third symbol
                        if (burst_last) begin
                            state_q <= ST_SEARCH;
                        end
                    end
                end
                default: state_q <= ST_SEARCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (lock_now) begin
            n_id_2_o <= peak_id_i;
        end
        if (dly_valid_i) begin
            out_data_o <= dly_data_i;
        end
    end

endmodule

//--- hdl/sample_delay.sv
`timescale 1ns/1ps

module sample_delay #(
    parameter int DEPTH = 2
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic [receiver_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                              in_valid_i,
    output logic [receiver_pkg::SAMPLE_W-1:0] out_data_o,
    output logic                              out_valid_o
);

    logic [receiver_pkg::SAMPLE_W-1:0] data_q  [DEPTH];
    logic                              valid_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= in_valid_i;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        data_q[0] <= in_data_i;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_data_o  = data_q[DEPTH-1];
    assign out_valid_o = valid_q[DEPTH-1];

endmodule

//--- pss_detector/pss_detector.sv
`timescale 1ns/1ps

module pss_detector #(
    parameter int PSS_THRESH = 14
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic [receiver_pkg::SAMPLE_W-1:0] dec_data_i,
    input  logic                              dec_valid_i,
    input  logic                              search_en_i,
    output logic                              peak_valid_o,
    output logic [receiver_pkg::NID2_W-1:0]   peak_id_o
);

    localparam int PSS_LEN = receiver_pkg::PSS_LEN;
    localparam int IQ_W = receiver_pkg::IQ_W;
    localparam int NID2_W = receiver_pkg::NID2_W;
    localparam int NUM_SEQ = 3;
    localparam int CNT_W = $clog2(PSS_LEN + 1);
    localparam logic [CNT_W-1:0] THRESH = CNT_W'(PSS_THRESH);

    logic [PSS_LEN-1:0] window_q;
    logic               win_valid_q;
    logic               cnt_valid_q;
    logic [CNT_W-1:0]   match_cnt_q [NUM_SEQ];
    logic               peak_hit;
    logic [NID2_W-1:0]  peak_sel;

    function automatic logic [CNT_W-1:0] agree_count(
        input logic [PSS_LEN-1:0] win,
        input logic [PSS_LEN-1:0] seq
    );
        logic [PSS_LEN-1:0] same;
        logic [CNT_W-1:0]   n;
        same = ~(win ^ seq);
        n = '0;
        for (int i = 0; i < PSS_LEN; i++) begin
            n = n + CNT_W'(same[i]);
        end
        return n;
    endfunction

    // newest sample enters at the lsb, so the oldest sits at the msb
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            window_q    <= '0;
            win_valid_q <= 1'b0;
            cnt_valid_q <= 1'b0;
        end else begin
            win_valid_q <= dec_valid_i;
            cnt_valid_q <= win_valid_q;
            if (dec_valid_i) begin
                window_q <= {window_q[PSS_LEN-2:0], ~dec_data_i[IQ_W-1]};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (win_valid_q) begin
            for (int k = 0; k < NUM_SEQ; k++) begin
                match_cnt_q[k] <= agree_count(window_q, receiver_pkg::PSS_SEQ[k]);
            end
        end
    end

    // walk down so the lowest qualifying index is the one left
    always_comb begin
        peak_hit = 1'b0;
        peak_sel = '0;
        for (int k = NUM_SEQ - 1; k >= 0; k--) begin
            if (match_cnt_q[k] >= THRESH) begin
                peak_hit = 1'b1;
                peak_sel = NID2_W'(k);
            end
        end
    end

    assign peak_valid_o = cnt_valid_q && search_en_i && peak_hit;
    assign peak_id_o    = peak_sel;

endmodule

//--- hdl/sample_decimator.sv
`timescale 1ns/1ps

module sample_decimator (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic [receiver_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic                              in_valid_i,
    output logic [receiver_pkg::SAMPLE_W-1:0] dec_data_o,
    output logic                              dec_valid_o
);

    localparam int IQ_W = receiver_pkg::IQ_W;

    logic [receiver_pkg::SAMPLE_W-1:0] first_q;
    logic                              phase_q;
    logic signed [IQ_W:0]              sum_re;
    logic signed [IQ_W:0]              sum_im;

    // one bit of growth, so the sums cannot overflow
    always_comb begin
        sum_re = $signed(first_q[IQ_W-1:0]) + $signed(in_data_i[IQ_W-1:0]);
        sum_im = $signed(first_q[2*IQ_W-1:IQ_W]) + $signed(in_data_i[2*IQ_W-1:IQ_W]);
    end

    // phase only moves on valid inputs so gaps keep the pairing
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q     <= 1'b0;
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= in_valid_i && phase_q;
            if (in_valid_i) begin
                phase_q <= ~phase_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && !phase_q) begin
            first_q <= in_data_i;
        end
        // dropping the lsb of the sum is the arithmetic shift by one
        if (in_valid_i && phase_q) begin
            dec_data_o <= {sum_im[IQ_W:1], sum_re[IQ_W:1]};
        end
    end

endmodule

//--- common/receiver_pkg.sv
package receiver_pkg;

    // packed complex sample, real part in the low half
    localparam int SAMPLE_W = 32;
    localparam int IQ_W = SAMPLE_W / 2;

    // index of the primary sync sequence, 0 to 2
    localparam int NID2_W = 2;

    // sync sequence length in decimated samples
    localparam int PSS_LEN = 16;

    // local sync patterns, one bit per decimated sample
    // bit set means a non-negative real part is expected
    // the msb is the first sample of the sequence on air
    localparam logic [PSS_LEN-1:0] PSS_SEQ_0 = 16'hEB22;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_1 = 16'h4DD8;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_2 = 16'h3A5F;

    // pairwise distance between the patterns is 10 bits
    localparam logic [2:0][PSS_LEN-1:0] PSS_SEQ = {
        PSS_SEQ_2,
        PSS_SEQ_1,
        PSS_SEQ_0
    };

endpackage
